// ==== project.f ====
rtl/bmp180_pkg.sv
rtl/conv_timer.sv
rtl/coeff_store.sv
rtl/rx_assembler.sv
rtl/bmp180_sequencer.sv
rtl/bmp180_top.sv
verif/tb_clock_gen.sv
verif/bmp180_sensor_model.sv
verif/bmp180_tb.sv

// ==== rtl/bmp180_pkg.sv ====
// BMP180 command codes, register map, control bytes, conversion times, widths, rx word union
package bmp180_pkg;

    typedef logic [3:0]  cmd_t;
    typedef logic [1:0]  oss_t;
    typedef logic [3:0]  coeff_addr_t;
    typedef logic [15:0] coeff_word_t;
    typedef logic [18:0] up_t;

    localparam cmd_t READ_CC  = 4'd1;  // read calibration coefficients
    localparam cmd_t MSR_PRS0 = 4'd2;  // temperature then pressure, oss 0
    localparam cmd_t MSR_PRS1 = 4'd3;
    localparam cmd_t MSR_PRS2 = 4'd4;
    localparam cmd_t MSR_PRS3 = 4'd5;  // oss 3, longest conversion
    localparam cmd_t CHECK    = 4'd7;  // chip id check

    localparam logic [6:0] DEV_ADDR = 7'h77;  // sensor address on the bus

    localparam logic [7:0] REG_CALIB   = 8'hAA;  // first calibration byte, AC1 msb
    localparam logic [7:0] REG_CTRL    = 8'hF4;  // measurement control
    localparam logic [7:0] REG_OUT_MSB = 8'hF6;  // out_msb, out_lsb, out_xlsb follow
    localparam logic [7:0] REG_CHIP_ID = 8'hD0;

    localparam logic [7:0] CTRL_TEMP       = 8'h2E;
    localparam logic [7:0] CTRL_PRESS_BASE = 8'h34;  // oss goes in bits 7:6
    localparam logic [7:0] CHIP_ID         = 8'h55;

    localparam int CALIB_WORDS = 11;
    localparam int CALIB_BYTES = 22;
    localparam int BYTE_CNT_W  = $clog2(CALIB_BYTES + 1);

    // conversion time in tenths of a millisecond, indexed by oss
    localparam logic [3:0][9:0] CONV_TENTHS_MS = {10'd255, 10'd135, 10'd75, 10'd45};

    localparam oss_t TEMP_CONV_IDX = 2'd0;  // temperature uses the oss 0 time

    // the same three received bytes read as UT or as raw UP
    typedef union packed {
        struct packed {
            logic [7:0] spare;
            logic [7:0] msb;
            logic [7:0] lsb;
        } temp;
        struct packed {
            logic [7:0] msb;
            logic [7:0] lsb;
            logic [7:0] xlsb;
        } press;
    } rx_word_u;

endpackage

// ==== rtl/bmp180_sequencer.sv ====
`timescale 1ns/10ps
// BMP180 command FSM driving the I2C master, busy edge detection and byte counting
module bmp180_sequencer
(
    input  logic             CLK,
    input  logic             RST_n,
    input  bmp180_pkg::cmd_t cmd,
    input  logic             i2c_busy,
    input  logic [7:0]       i2c_data_rd,
    input  logic             conv_done,
    output logic             i2c_en,
    output logic [6:0]       i2c_addr,
    output logic             i2c_rw,
    output logic [7:0]       i2c_data_wr,
    output logic             cmd_busy,
    output logic             err,
    output bmp180_pkg::oss_t oss,
    output logic             byte_rx,
    output logic             calib_cap,
    output logic             ut_load,
    output logic             up_load,
    output logic             conv_start
);
    import bmp180_pkg::*;

    // each read state sits one bit above its pointer state
    localparam logic [8:0] ST_IDLE     = 9'b0_0000_0001;
    localparam logic [8:0] ST_CAL_PTR  = 9'b0_0000_0010;
    localparam logic [8:0] ST_CAL_RD   = 9'b0_0000_0100;
    localparam logic [8:0] ST_MSR_WR   = 9'b0_0000_1000;
    localparam logic [8:0] ST_MSR_WAIT = 9'b0_0001_0000;
    localparam logic [8:0] ST_MSR_PTR  = 9'b0_0010_0000;
    localparam logic [8:0] ST_MSR_RD   = 9'b0_0100_0000;
    localparam logic [8:0] ST_CHK_PTR  = 9'b0_1000_0000;
    localparam logic [8:0] ST_CHK_RD   = 9'b1_0000_0000;

    logic [8:0]            st;
    logic                  busy_s1;      // busy synchronizer
    logic                  busy_s2;
    logic                  busy_rise;
    logic                  busy_fall;
    logic                  rd_state;
    logic                  cmd_msr;
    logic                  cmd_known;
    logic [BYTE_CNT_W-1:0] byte_cnt;     // bytes left in the transfer
    oss_t                  oss_cmd;      // oss from the command
    logic                  press_phase;  // second pass of a measurement

    assign busy_rise = busy_s1 & ~busy_s2;
    assign busy_fall = ~busy_s1 & busy_s2;
    assign rd_state  = (st == ST_CAL_RD) || (st == ST_MSR_RD) || (st == ST_CHK_RD);
    assign byte_rx   = busy_fall & rd_state;

    assign cmd_msr   = (cmd >= MSR_PRS0) && (cmd <= MSR_PRS3);
    assign cmd_known = (cmd == READ_CC) || cmd_msr || (cmd == CHECK);

    always_ff @(posedge CLK or negedge RST_n)
    begin
        if (!RST_n)
        begin
            st          <= ST_IDLE;
            busy_s1     <= 1'b0;
            busy_s2     <= 1'b0;
            byte_cnt    <= '0;
            oss_cmd     <= '0;
            press_phase <= 1'b0;
            i2c_en      <= 1'b0;
            i2c_addr    <= '0;
            i2c_rw      <= 1'b0;
            i2c_data_wr <= '0;
            cmd_busy    <= 1'b0;
            err         <= 1'b0;
            oss         <= '0;
            calib_cap   <= 1'b0;
            ut_load     <= 1'b0;
            up_load     <= 1'b0;
            conv_start  <= 1'b0;
        end
        else
        begin
            busy_s1    <= i2c_busy;
            busy_s2    <= busy_s1;
            ut_load    <= 1'b0;
            up_load    <= 1'b0;
            conv_start <= 1'b0;
            case (st)
                ST_IDLE:
                begin
                    if (cmd_known)
                    begin
                        i2c_en   <= 1'b1;      // pointer write first
                        i2c_addr <= DEV_ADDR;
                        i2c_rw   <= 1'b0;
                        cmd_busy <= 1'b1;
                        err      <= 1'b0;
                    end
                    if (cmd == READ_CC)
                    begin
                        i2c_data_wr <= REG_CALIB;
                        st          <= ST_CAL_PTR;
                    end
                    else if (cmd_msr)
                    begin
                        i2c_data_wr <= REG_CTRL;
                        oss_cmd     <= oss_t'(cmd - MSR_PRS0);
                        oss         <= TEMP_CONV_IDX;  // temperature pass
                        press_phase <= 1'b0;
                        byte_cnt    <= BYTE_CNT_W'(2);
                        st          <= ST_MSR_WR;
                    end
                    else if (cmd == CHECK)
                    begin
                        i2c_data_wr <= REG_CHIP_ID;
                        st          <= ST_CHK_PTR;
                    end
                end
                ST_MSR_WR:
                begin
                    if (busy_rise)
                    begin
                        byte_cnt <= byte_cnt - 1'b1;
                        if (byte_cnt == 2)
                            i2c_data_wr <= press_phase ? {oss_cmd, CTRL_PRESS_BASE[5:0]}
                                                       : CTRL_TEMP;
                        if (byte_cnt == 1)
                            i2c_en <= 1'b0;   // control byte is the last one
                    end
                    if (busy_fall && byte_cnt == 0)
                    begin
                        conv_start <= 1'b1;
                        st         <= ST_MSR_WAIT;
                    end
                end
                ST_MSR_WAIT:
                begin
                    if (conv_done)
                    begin
                        i2c_en      <= 1'b1;
                        i2c_rw      <= 1'b0;
                        i2c_data_wr <= REG_OUT_MSB;
                        st          <= ST_MSR_PTR;
                    end
                end
                ST_CAL_PTR, ST_MSR_PTR, ST_CHK_PTR:
                begin
                    if (busy_rise)
                        i2c_en <= 1'b0;       // pointer only
                    if (busy_fall)
                    begin
                        i2c_en    <= 1'b1;    // repeated start for the read
                        i2c_rw    <= 1'b1;
                        calib_cap <= (st == ST_CAL_PTR);
                        st        <= {st[7:0], 1'b0};
                        if (st == ST_CAL_PTR)
                            byte_cnt <= BYTE_CNT_W'(CALIB_BYTES);
                        else if (st == ST_MSR_PTR)
                            byte_cnt <= press_phase ? BYTE_CNT_W'(3) : BYTE_CNT_W'(2);
                        else
                            byte_cnt <= BYTE_CNT_W'(1);
                    end
                end
                ST_CAL_RD, ST_MSR_RD, ST_CHK_RD:
                begin
                    if (busy_rise && byte_cnt == 1)
                        i2c_en <= 1'b0;       // single byte read
                    if (busy_fall)
                    begin
                        byte_cnt <= byte_cnt - 1'b1;
                        if (byte_cnt == 2)
                            i2c_en <= 1'b0;   // last byte already started
                        if (byte_cnt == 1)
                        begin
                            if (st == ST_MSR_RD && !press_phase)
                            begin
                                // UT done, now start the pressure conversion
                                ut_load     <= 1'b1;
                                i2c_en      <= 1'b1;
                                i2c_rw      <= 1'b0;
                                i2c_data_wr <= REG_CTRL;
                                byte_cnt    <= BYTE_CNT_W'(2);
                                press_phase <= 1'b1;
                                oss         <= oss_cmd;
                                st          <= ST_MSR_WR;
                            end
                            else
                            begin
                                up_load   <= (st == ST_MSR_RD);
                                calib_cap <= 1'b0;
                                cmd_busy  <= 1'b0;
                                st        <= ST_IDLE;
                                if (st == ST_CHK_RD)
                                    err <= (i2c_data_rd != CHIP_ID);
                            end
                        end
                    end
                end
                default:
                begin
                    i2c_en    <= 1'b0;
                    calib_cap <= 1'b0;
                    cmd_busy  <= 1'b0;
                    st        <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== rtl/bmp180_top.sv ====
`timescale 1ns/10ps
// BMP180 sequencer top with conversion timer, coefficient store and rx assembler
module bmp180_top
#(
    parameter int CLK_KHZ = 50_000
)
(
    input  logic                    CLK,
    input  logic                    RST_n,
    input  bmp180_pkg::cmd_t        cmd,
    input  logic                    i2c_busy,
    input  logic [7:0]              i2c_data_rd,
    input  bmp180_pkg::coeff_addr_t coeff_addr,
    output logic                    i2c_en,
    output logic [6:0]              i2c_addr,
    output logic                    i2c_rw,
    output logic [7:0]              i2c_data_wr,
    output logic                    cmd_busy,
    output logic                    err,
    output bmp180_pkg::oss_t        oss,
    output logic [15:0]             ut,
    output logic                    ut_valid,
    output bmp180_pkg::up_t         up,
    output logic                    up_valid,
    output bmp180_pkg::coeff_word_t coeff_data
);
    logic byte_rx;     // one per received byte
    logic calib_cap;
    logic ut_load;
    logic up_load;
    logic conv_start;
    logic conv_done;

    bmp180_sequencer bmp180_sequencer_i
    (
        .CLK         (CLK),
        .RST_n       (RST_n),
        .cmd         (cmd),
        .i2c_busy    (i2c_busy),
        .i2c_data_rd (i2c_data_rd),
        .conv_done   (conv_done),
        .i2c_en      (i2c_en),
        .i2c_addr    (i2c_addr),
        .i2c_rw      (i2c_rw),
        .i2c_data_wr (i2c_data_wr),
        .cmd_busy    (cmd_busy),
        .err         (err),
        .oss         (oss),
        .byte_rx     (byte_rx),
        .calib_cap   (calib_cap),
        .ut_load     (ut_load),
        .up_load     (up_load),
        .conv_start  (conv_start)
    );

    conv_timer #(.CLK_KHZ(CLK_KHZ)) conv_timer_i
    (
        .CLK        (CLK),
        .RST_n      (RST_n),
        .conv_start (conv_start),
        .oss        (oss),        // zero during the temperature pass
        .conv_done  (conv_done)
    );

    coeff_store coeff_store_i
    (
        .CLK         (CLK),
        .RST_n       (RST_n),
        .calib_cap   (calib_cap),
        .byte_rx     (byte_rx),
        .i2c_data_rd (i2c_data_rd),
        .coeff_addr  (coeff_addr),
        .coeff_data  (coeff_data)
    );

    rx_assembler rx_assembler_i
    (
        .CLK         (CLK),
        .RST_n       (RST_n),
        .byte_rx     (byte_rx),
        .i2c_data_rd (i2c_data_rd),
        .ut_load     (ut_load),
        .up_load     (up_load),
        .oss         (oss),
        .ut          (ut),
        .ut_valid    (ut_valid),
        .up          (up),
        .up_valid    (up_valid)
    );

endmodule

// ==== rtl/coeff_store.sv ====
`timescale 1ns/10ps
// calibration byte pairing and eleven word coefficient store with registered read port
module coeff_store
(
    input  logic                    CLK,
    input  logic                    RST_n,
    input  logic                    calib_cap,
    input  logic                    byte_rx,
    input  logic [7:0]              i2c_data_rd,
    input  bmp180_pkg::coeff_addr_t coeff_addr,
    output bmp180_pkg::coeff_word_t coeff_data
);
    import bmp180_pkg::*;

    coeff_word_t mem [CALIB_WORDS];  // 0 is AC1, 10 is MD
    coeff_word_t wr_data;
    coeff_addr_t wr_addr;
    logic [7:0]  msb_q;
    logic        lsb_next;           // next byte closes a pair
    logic        wr_en;
    logic        cap_q;
    logic        take;

    assign take = calib_cap & byte_rx;

    always_ff @(posedge CLK or negedge RST_n)
    begin
        if (!RST_n)
        begin
            cap_q    <= 1'b0;
            lsb_next <= 1'b0;
            wr_en    <= 1'b0;
            wr_addr  <= '0;
        end
        else
        begin
            cap_q <= calib_cap;
            wr_en <= take & lsb_next;
            if (calib_cap && !cap_q)
            begin
                lsb_next <= 1'b0;  // new calibration read
                wr_addr  <= '0;
            end
            else
            begin
                if (take)
                    lsb_next <= ~lsb_next;
                if (wr_en)
                    wr_addr <= wr_addr + 1'b1;
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (take && !lsb_next)
            msb_q <= i2c_data_rd;
        if (take && lsb_next)
            wr_data <= {msb_q, i2c_data_rd};  // msb first
        if (wr_en && wr_addr < CALIB_WORDS)
            mem[wr_addr] <= wr_data;
        coeff_data <= (coeff_addr < CALIB_WORDS) ? mem[coeff_addr] : '0;
    end

endmodule

// ==== rtl/conv_timer.sv ====
`timescale 1ns/10ps
// conversion wait counter with a limit per oversampling setting
module conv_timer
#(
    parameter int CLK_KHZ = 50_000
)
(
    input  logic             CLK,
    input  logic             RST_n,
    input  logic             conv_start,
    input  bmp180_pkg::oss_t oss,
    output logic             conv_done
);
    import bmp180_pkg::*;

    localparam int MAX_CYC = CLK_KHZ * int'(CONV_TENTHS_MS[3]) / 10;
    localparam int CNT_W   = $clog2(MAX_CYC + 2);

    logic [CNT_W-1:0] cnt;
    logic [CNT_W-1:0] limit;  // cycles for the running conversion
    logic             armed;

    // constant table lookup, khz times tenths of ms over ten gives cycles
    function automatic logic [CNT_W-1:0] cycles_for(input oss_t sel);
        int tenths;
        tenths = int'(CONV_TENTHS_MS[sel]);
        return CNT_W'(CLK_KHZ * tenths / 10);
    endfunction

    always_ff @(posedge CLK or negedge RST_n)
    begin
        if (!RST_n)
        begin
            cnt   <= '0;
            limit <= '0;
            armed <= 1'b0;
        end
        else if (conv_start)
        begin
            cnt   <= CNT_W'(1);
            limit <= cycles_for(oss);
            armed <= 1'b1;
        end
        else if (armed && cnt < limit)
            cnt <= cnt + 1'b1;  // saturates at the limit
    end

    assign conv_done = armed && !conv_start && (cnt >= limit);

endmodule

// ==== rtl/rx_assembler.sv ====
`timescale 1ns/10ps
// received byte shift register and UT / UP output registers with valid pulses
module rx_assembler
(
    input  logic             CLK,
    input  logic             RST_n,
    input  logic             byte_rx,
    input  logic [7:0]       i2c_data_rd,
    input  logic             ut_load,
    input  logic             up_load,
    input  bmp180_pkg::oss_t oss,
    output logic [15:0]      ut,
    output logic             ut_valid,
    output bmp180_pkg::up_t  up,
    output logic             up_valid
);
    import bmp180_pkg::*;

    rx_word_u    rx_q;
    logic [23:0] press_raw;

    assign press_raw = {rx_q.press.msb, rx_q.press.lsb, rx_q.press.xlsb};

    // oldest byte falls off the top
    always_ff @(posedge CLK)
    begin
        if (byte_rx)
            rx_q.press <= {rx_q.press.lsb, rx_q.press.xlsb, i2c_data_rd};
    end

    always_ff @(posedge CLK)
    begin
        if (ut_load)
            ut <= {rx_q.temp.msb, rx_q.temp.lsb};
        if (up_load)
            up <= up_t'(press_raw >> (4'd8 - 4'(oss)));  // keep 16 + oss bits
    end

    always_ff @(posedge CLK or negedge RST_n)
    begin
        if (!RST_n)
        begin
            ut_valid <= 1'b0;
            up_valid <= 1'b0;
        end
        else
        begin
            ut_valid <= ut_load;
            up_valid <= up_load;
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the BMP180 sequencer testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal \
    --top-module bmp180_tb \
    -f project.f \
    --Mdir obj_dir -o bmp180_sim
./obj_dir/bmp180_sim

// ==== verif/bmp180_sensor_model.sv ====
// behavioral byte level I2C master with BMP180 register image and conversion wait check
`timescale 1ns/10ps
module bmp180_sensor_model
#(
    parameter int CLK_KHZ = 10
)
(
    input  logic             CLK,
    input  logic             RST_n,
    input  logic             i2c_en,
    input  logic [6:0]       i2c_addr,
    input  logic             i2c_rw,
    input  logic [7:0]       i2c_data_wr,
    input  logic [21:0][7:0] calib,     // image of 0xAA to 0xBF
    input  logic [7:0]       chip_id,
    input  logic [15:0]      ut_val,
    input  logic [23:0]      up_val,
    output logic             i2c_busy,
    output logic [7:0]       i2c_data_rd,
    output logic             fault
);
    localparam int BUSY_CYCLES = 4;
    localparam int GAP_CYCLES  = 2;

    logic [7:0] ptr;        // register pointer
    logic [7:0] ctrl;       // last control byte
    int         cycle = 0;
    int         ctrl_done;  // cycle the last control write ended
    int         conv_need;

    // 0x2E starts temperature, otherwise oss sits in bits 7:6
    function automatic int conv_cycles(input logic [7:0] c);
        int tenths;
        case ((c == 8'h2E) ? 2'd0 : c[7:6])
            2'd0:    tenths = 45;
            2'd1:    tenths = 75;
            2'd2:    tenths = 135;
            default: tenths = 255;
        endcase
        return CLK_KHZ * tenths / 10;
    endfunction

    function automatic logic [7:0] reg_value(input logic [7:0] a);
        logic temp;
        temp = (ctrl == 8'h2E);
        if (a >= 8'hAA && a <= 8'hBF)
            return calib[a - 8'hAA];
        case (a)
            8'hD0:   return chip_id;
            8'hF4:   return ctrl;
            8'hF6:   return temp ? ut_val[15:8] : up_val[23:16];
            8'hF7:   return temp ? ut_val[7:0] : up_val[15:8];
            8'hF8:   return temp ? 8'h00 : up_val[7:0];
            default: return 8'h00;
        endcase
    endfunction

    task automatic report_fault(input string what);
        $display("ERROR at %0t ns: %s", $time, what);
        fault = 1'b1;
    endtask

    task automatic run_transfer();
        logic       rd;
        logic [7:0] wr_byte;
        int         n;
        rd = i2c_rw;
        n  = 0;
        if (i2c_addr != 7'h77)
            report_fault("transfer addressed to the wrong device");
        if (rd && ptr == 8'hF6 && cycle - ctrl_done < conv_need)
            report_fault("conversion wait too short");
        do
        begin
            wr_byte = i2c_data_wr;  // taken as busy rises
            #1;
            i2c_busy = 1'b1;
            repeat (BUSY_CYCLES) @(posedge CLK);
            #1;
            i2c_busy = 1'b0;
            if (rd)
            begin
                i2c_data_rd = reg_value(ptr);
                ptr         = ptr + 8'd1;  // auto increment
            end
            else if (n == 0)
                ptr = wr_byte;
            else if (n == 1 && ptr == 8'hF4)
            begin
                ctrl      = wr_byte;
                ctrl_done = cycle;
                conv_need = conv_cycles(wr_byte);
            end
            else
                report_fault("unexpected data byte in a write transfer");
            n = n + 1;
            repeat (GAP_CYCLES) @(posedge CLK);
        end
        while (i2c_en);  // en low here ends the transfer
    endtask

    always @(posedge CLK)
        cycle <= cycle + 1;

    initial
    begin
        i2c_busy    = 1'b0;
        i2c_data_rd = 8'h00;
        fault       = 1'b0;
        ptr         = 8'h00;
        ctrl        = 8'h00;
        ctrl_done   = 0;
        conv_need   = 0;
        forever
        begin
            @(posedge CLK);
            if (RST_n && i2c_en)
                run_transfer();
        end
    end

endmodule

// ==== verif/bmp180_tb.sv ====
// BMP180 sequencer testbench top with DUT, sensor model, directed tests and checks
`timescale 1ns/10ps
module bmp180_tb;
    import bmp180_pkg::*;

    localparam int CLK_KHZ   = 10;      // conversion limits of 45 to 255 cycles
    localparam int CMD_LIMIT = 20_000;  // longest command is well under 1000 cycles
    localparam int SEED      = 69045;

    logic             CLK;
    logic             RST_n;
    cmd_t             cmd;
    coeff_addr_t      coeff_addr;
    logic             i2c_busy;
    logic [7:0]       i2c_data_rd;
    logic             i2c_en;
    logic [6:0]       i2c_addr;
    logic             i2c_rw;
    logic [7:0]       i2c_data_wr;
    logic             cmd_busy;
    logic             err;
    oss_t             oss;
    logic [15:0]      ut;
    logic             ut_valid;
    up_t              up;
    logic             up_valid;
    coeff_word_t      coeff_data;
    logic [21:0][7:0] calib;
    logic [7:0]       chip_id;
    logic [15:0]      ut_val;
    logic [23:0]      up_val;
    logic             model_fault;
    int               ut_pulses = 0;
    int               up_pulses = 0;

    tb_clock_gen clock_gen_i
    (
        .CLK   (CLK),
        .RST_n (RST_n)
    );

    bmp180_top #(.CLK_KHZ(CLK_KHZ)) bmp180_top_i
    (
        .CLK         (CLK),
        .RST_n       (RST_n),
        .cmd         (cmd),
        .i2c_busy    (i2c_busy),
        .i2c_data_rd (i2c_data_rd),
        .coeff_addr  (coeff_addr),
        .i2c_en      (i2c_en),
        .i2c_addr    (i2c_addr),
        .i2c_rw      (i2c_rw),
        .i2c_data_wr (i2c_data_wr),
        .cmd_busy    (cmd_busy),
        .err         (err),
        .oss         (oss),
        .ut          (ut),
        .ut_valid    (ut_valid),
        .up          (up),
        .up_valid    (up_valid),
        .coeff_data  (coeff_data)
    );

    bmp180_sensor_model #(.CLK_KHZ(CLK_KHZ)) sensor_i
    (
        .CLK         (CLK),
        .RST_n       (RST_n),
        .i2c_en      (i2c_en),
        .i2c_addr    (i2c_addr),
        .i2c_rw      (i2c_rw),
        .i2c_data_wr (i2c_data_wr),
        .calib       (calib),
        .chip_id     (chip_id),
        .ut_val      (ut_val),
        .up_val      (up_val),
        .i2c_busy    (i2c_busy),
        .i2c_data_rd (i2c_data_rd),
        .fault       (model_fault)
    );

    always @(posedge CLK)
    begin
        if (ut_valid)
            ut_pulses <= ut_pulses + 1;
        if (up_valid)
            up_pulses <= up_pulses + 1;
    end

    always @(posedge model_fault)
    begin
        $display("Done: errors found");
        $fatal(1, "sensor model found a protocol error");
    end

    task automatic check_eq(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("FAILED at %0t ns: %s is 0x%0h, expected 0x%0h",
                     $time, name, got, exp);
            $display("Done: errors found");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic step_cycle();
        @(posedge CLK);
        #1;
    endtask

    // entered 1 ns after an edge, the DUT takes the code at the next edge
    task automatic start_cmd(input cmd_t code);
        cmd = code;
        step_cycle();
        cmd = 4'd0;
        check_eq("cmd_busy", 32'(cmd_busy), 32'd1);
    endtask

    task automatic wait_cmd_done();
        int cycles;
        cycles = 0;
        while (cmd_busy)
        begin
            step_cycle();
            cycles = cycles + 1;
            if (cycles > CMD_LIMIT)
            begin
                $display("ERROR at %0t ns: cmd_busy still high after %0d cycles",
                         $time, CMD_LIMIT);
                $display("Done: errors found");
                $fatal(1, "timeout");
            end
        end
    endtask

    task automatic test_reset_state();
        check_eq("i2c_en", 32'(i2c_en), 32'd0);
        check_eq("cmd_busy", 32'(cmd_busy), 32'd0);
        check_eq("err", 32'(err), 32'd0);
        check_eq("ut_valid", 32'(ut_valid), 32'd0);
        check_eq("up_valid", 32'(up_valid), 32'd0);
    endtask

    task automatic test_read_cc();
        int k;
        start_cmd(READ_CC);
        wait_cmd_done();
        for (k = 0; k < 11; k++)
        begin
            coeff_addr = coeff_addr_t'(k);
            step_cycle();  // registered read port
            check_eq($sformatf("coeff_data[%0d]", k), 32'(coeff_data),
                     32'({calib[2 * k], calib[2 * k + 1]}));
        end
    endtask

    task automatic test_measure(input oss_t sel);
        int ut_before;
        int up_before;
        ut_val    = 16'($urandom);
        up_val    = 24'($urandom);
        ut_before = ut_pulses;
        up_before = up_pulses;
        start_cmd(MSR_PRS0 + cmd_t'(sel));
        wait_cmd_done();
        repeat (3) step_cycle();  // up_valid trails the last byte
        check_eq("ut_valid pulses", 32'(ut_pulses - ut_before), 32'd1);
        check_eq("up_valid pulses", 32'(up_pulses - up_before), 32'd1);
        check_eq("ut", 32'(ut), 32'(ut_val));
        check_eq("up", 32'(up), 32'(up_val >> (8 - sel)));
        check_eq("oss", 32'(oss), 32'(sel));
    endtask

    task automatic test_chip_id();
        chip_id = 8'h55;
        start_cmd(CHECK);
        wait_cmd_done();
        check_eq("err", 32'(err), 32'd0);
        chip_id = 8'($urandom);
        if (chip_id == 8'h55)
            chip_id = 8'hA5;
        start_cmd(CHECK);
        wait_cmd_done();
        check_eq("err", 32'(err), 32'd1);
        chip_id = 8'h55;
        start_cmd(CHECK);
        check_eq("err", 32'(err), 32'd0);  // cleared as the command starts
        wait_cmd_done();
        check_eq("err", 32'(err), 32'd0);
    endtask

    task automatic test_unknown_cmd(input cmd_t code);
        int n;
        cmd = code;
        for (n = 0; n < 50; n++)
        begin
            step_cycle();
            check_eq("cmd_busy", 32'(cmd_busy), 32'd0);
            check_eq("i2c_en", 32'(i2c_en), 32'd0);
        end
        cmd = 4'd0;
    endtask

    initial
    begin
        int i;
        void'($urandom(SEED));
        cmd        = 4'd0;
        coeff_addr = '0;
        chip_id    = 8'h55;
        ut_val     = '0;
        up_val     = '0;
        for (i = 0; i < 22; i++)
            calib[i] = 8'($urandom);
        wait (RST_n === 1'b1);
        step_cycle();
        test_reset_state();
        test_read_cc();
        test_measure(2'd0);
        test_measure(2'd3);
        test_chip_id();
        test_unknown_cmd(4'd6);
        test_unknown_cmd(4'd15);
        $display("Done: no errors");
        $finish;
    end

endmodule

// ==== verif/tb_clock_gen.sv ====
// testbench clock and active low reset generator
`timescale 1ns/10ps
module tb_clock_gen
#(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 8
)
(
    output logic CLK,
    output logic RST_n
);
    initial
    begin
        CLK = 1'b0;
        forever
            #(PERIOD_NS / 2) CLK = ~CLK;
    end

    initial
    begin
        RST_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        #1;
        RST_n = 1'b1;  // released just after an edge
    end

endmodule
